// ==== bus_decoder.sv ====
`timescale 1ns/1ns

`include "soc_consts.svh"

module bus_decoder (
    input  logic sys_clk,
    input  logic rst_n_i,

    input  logic wr_req_i,
    input  logic [`SOC_DATA_W-1:0] wr_addr_i,
    input  logic [`SOC_DATA_W-1:0] wr_data_i,
    input  soc_pkg::access_width_e wr_width_i,
    input  logic rd_req_i,
    input  logic [`SOC_DATA_W-1:0] rd_addr_i,

    output logic wr_done_o,
    output logic rd_done_o,
    output logic [`SOC_DATA_W-1:0] rd_data_o,
    output logic bus_err_o,

    slave_bus_if.master ram_bus,
    slave_bus_if.master tmr_bus,
    slave_bus_if.master gpio_bus
);

    logic [`SOC_DATA_W-1:0] req_addr;
    logic [`SOC_DATA_W-1:0] offset;
    logic [`SOC_DATA_W-1:0] slave_rdata;
    logic [3:0] strb;
    logic slave_err;
    logic wr_q;
    logic rd_q;
    soc_pkg::slave_sel_e sel;
    soc_pkg::slave_sel_e sel_q;

// ====================
// Address decode
// ====================

    // Reads and writes never overlap
    assign req_addr = wr_req_i ? wr_addr_i : rd_addr_i;

    always_comb begin
        sel = soc_pkg::SEL_NONE;
        offset = '0;
        // RAM region covers everything below the peripherals
        if (req_addr < `TIMER_BASE) begin
            sel = soc_pkg::SEL_RAM;
            offset = req_addr - `RAM_BASE;
        end else if ((req_addr - `TIMER_BASE) < `SLAVE_WINDOW) begin
            sel = soc_pkg::SEL_TIMER;
            offset = req_addr - `TIMER_BASE;
        end else if ((req_addr - `GPIO_BASE) < `SLAVE_WINDOW) begin
            sel = soc_pkg::SEL_GPIO;
            offset = req_addr - `GPIO_BASE;
        end
    end

    // Byte lanes, write data stays in place
    always_comb begin
        case (wr_width_i)
            soc_pkg::ACC_WORD: strb = 4'b1111;
            soc_pkg::ACC_HALF: strb = req_addr[1] ? 4'b1100 : 4'b0011;
            soc_pkg::ACC_BYTE: strb = 4'b0001 << req_addr[1:0];
            default:           strb = 4'b0000;
        endcase
    end

    assign ram_bus.wr_req    = wr_req_i && (sel == soc_pkg::SEL_RAM);
    assign ram_bus.rd_req    = rd_req_i && (sel == soc_pkg::SEL_RAM);
    assign ram_bus.word_addr = offset[`SOC_DATA_W-1:2];
    assign ram_bus.wdata     = wr_data_i;
    assign ram_bus.wstrb     = strb;

    assign tmr_bus.wr_req    = wr_req_i && (sel == soc_pkg::SEL_TIMER);
    assign tmr_bus.rd_req    = rd_req_i && (sel == soc_pkg::SEL_TIMER);
    assign tmr_bus.word_addr = offset[`SOC_DATA_W-1:2];
    assign tmr_bus.wdata     = wr_data_i;
    assign tmr_bus.wstrb     = strb;

    assign gpio_bus.wr_req    = wr_req_i && (sel == soc_pkg::SEL_GPIO);
    assign gpio_bus.rd_req    = rd_req_i && (sel == soc_pkg::SEL_GPIO);
    assign gpio_bus.word_addr = offset[`SOC_DATA_W-1:2];
    assign gpio_bus.wdata     = wr_data_i;
    assign gpio_bus.wstrb     = strb;

// ====================
// Response path
// ====================

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sel_q <= soc_pkg::SEL_NONE;
            wr_q <= 1'b0;
            rd_q <= 1'b0;
        end else begin
            sel_q <= sel;
            wr_q <= wr_req_i;
            rd_q <= rd_req_i;
        end
    end

    always_comb begin
        case (sel_q)
            soc_pkg::SEL_RAM: begin
                slave_rdata = ram_bus.rdata;
                slave_err = ram_bus.err;
            end
            soc_pkg::SEL_TIMER: begin
                slave_rdata = tmr_bus.rdata;
                slave_err = tmr_bus.err;
            end
            soc_pkg::SEL_GPIO: begin
                slave_rdata = gpio_bus.rdata;
                slave_err = gpio_bus.err;
            end
            // Nothing mapped here
            default: begin
                slave_rdata = '0;
                slave_err = 1'b1;
            end
        endcase
    end

    assign wr_done_o = wr_q;
    assign rd_done_o = rd_q;
    assign rd_data_o = rd_q ? slave_rdata : '0;
    assign bus_err_o = (wr_q | rd_q) & slave_err;

    no_dual_req: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        !(wr_req_i && rd_req_i));

endmodule : bus_decoder

// ==== data_ram.sv ====
`timescale 1ns/1ns

`include "soc_consts.svh"

module data_ram (
    input logic sys_clk,
    input logic rst_n_i,

    slave_bus_if.slave bus
);

    localparam int IDX_W = $clog2(`RAM_WORDS);

    logic [`SOC_DATA_W-1:0] mem [`RAM_WORDS];
    logic [IDX_W-1:0] idx;
    logic in_range;

    assign idx = bus.word_addr[IDX_W-1:0];
    assign in_range = bus.word_addr < `RAM_WORDS;

    // Byte-lane writes, registered reads
    always_ff @(posedge sys_clk) begin
        if (bus.wr_req && in_range) begin
            for (int i = 0; i < 4; i++) begin
                if (bus.wstrb[i]) begin
                    mem[idx][8*i +: 8] <= bus.wdata[8*i +: 8];
                end
            end
        end
        if (bus.rd_req) begin
            bus.rdata <= in_range ? mem[idx] : '0;
        end
    end

    // Offset past the last word
    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus.err <= 1'b0;
        end else begin
            bus.err <= (bus.wr_req | bus.rd_req) & ~in_range;
        end
    end

    wr_strobe_set: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        bus.wr_req |-> (bus.wstrb != 4'b0000));

endmodule : data_ram

// ==== gpio_port.sv ====
`timescale 1ns/1ns

`include "soc_consts.svh"

module gpio_port (
    input  logic sys_clk,
    input  logic rst_n_i,

    slave_bus_if.slave bus,

    input  logic [`GPIO_W-1:0] gpio_in_i,
    output logic [`GPIO_W-1:0] gpio_out_o,
    output logic irq_o
);

    soc_pkg::gpio_reg_e reg_idx;
    logic idx_ok;
    logic wr_bad;
    logic [`GPIO_W-1:0] out_q;
    logic [`GPIO_W-1:0] mask_q;
    logic [`GPIO_W-1:0] in_q;
    logic [1:0][`GPIO_W-1:0] sync_q;
    logic [`SOC_DATA_W-1:0] rd_word;

    assign idx_ok = bus.word_addr < `GPIO_REGS;
    assign reg_idx = soc_pkg::gpio_reg_e'(bus.word_addr[1:0]);
    // Input register is read-only
    assign wr_bad = !idx_ok || (reg_idx == soc_pkg::GPIO_IN);

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_q <= '0;
            mask_q <= '0;
            sync_q <= '0;
            in_q <= '0;
            irq_o <= 1'b0;
            bus.err <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], gpio_in_i};
            in_q <= sync_q[1];
            // Edge on any unmasked pin
            irq_o <= |((sync_q[1] ^ in_q) & mask_q);
            bus.err <= (bus.wr_req & wr_bad) | (bus.rd_req & ~idx_ok);
            if (bus.wr_req && idx_ok && bus.wstrb[0]) begin
                if (reg_idx == soc_pkg::GPIO_OUT) begin
                    out_q <= bus.wdata[`GPIO_W-1:0];
                end
                if (reg_idx == soc_pkg::GPIO_MASK) begin
                    mask_q <= bus.wdata[`GPIO_W-1:0];
                end
            end
        end
    end

    always_comb begin
        rd_word = '0;
        case (reg_idx)
            soc_pkg::GPIO_OUT:  rd_word[`GPIO_W-1:0] = out_q;
            soc_pkg::GPIO_IN:   rd_word[`GPIO_W-1:0] = in_q;
            soc_pkg::GPIO_MASK: rd_word[`GPIO_W-1:0] = mask_q;
            default:            rd_word = '0;
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (bus.rd_req) begin
            bus.rdata <= rd_word;
        end
    end

    assign gpio_out_o = out_q;

endmodule : gpio_port

// ==== interrupt_controller.sv ====
`timescale 1ns/1ns

`include "soc_consts.svh"

module interrupt_controller (
    input  logic sys_clk,
    input  logic rst_n_i,

    input  logic [`IRQ_SOURCES-1:0] irq_src_i,
    input  logic irq_ack_i,

    output logic irq_o,
    output logic [$clog2(`IRQ_SOURCES)-1:0] irq_vector_o
);

    localparam int VEC_W = $clog2(`IRQ_SOURCES);

    logic [`IRQ_SOURCES-1:0] pending_q;
    logic [`IRQ_SOURCES-1:0] ack_clr;

    // Lowest pending index wins
    always_comb begin
        irq_vector_o = '0;
        for (int i = `IRQ_SOURCES - 1; i >= 0; i--) begin
            if (pending_q[i]) begin
                irq_vector_o = VEC_W'(i);
            end
        end
    end

    // Acknowledge targets the vector on display
    assign ack_clr = {{(`IRQ_SOURCES-1){1'b0}}, irq_ack_i} << irq_vector_o;

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q <= '0;
        end else begin
            // A new pulse beats a clear on the same line
            pending_q <= (pending_q & ~ack_clr) | irq_src_i;
        end
    end

    assign irq_o = |pending_q;

    ack_while_irq: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        irq_ack_i |-> irq_o);

endmodule : interrupt_controller

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_soc -f sim.f \
    > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }
./obj_dir/Vtb_soc > sim.log 2>&1
cat sim.log
grep -q "sim failed" sim.log && { echo "Result: FAIL"; exit 1; }
grep -q "sim passed" sim.log || { echo "Result: no pass line"; exit 1; }
echo "Result: PASS"

// ==== sim.f ====
+incdir+.
soc_pkg.sv
slave_bus_if.sv
bus_decoder.sv
data_ram.sv
gpio_port.sv
system_timer.sv
interrupt_controller.sv
soc_top.sv
tb_soc.sv

// ==== slave_bus_if.sv ====
`timescale 1ns/1ns

`include "soc_consts.svh"

interface slave_bus_if;

    // One-cycle request strobes
    logic wr_req;
    logic rd_req;

    // Word offset inside the slave window
    logic [`SOC_DATA_W-3:0] word_addr;

    logic [`SOC_DATA_W-1:0] wdata;
    logic [3:0] wstrb;

    // Registered by the slave on the request cycle
    logic [`SOC_DATA_W-1:0] rdata;
    logic err;

    modport master (
        output wr_req, rd_req, word_addr, wdata, wstrb,
        input  rdata, err
    );

    modport slave (
        input  wr_req, rd_req, word_addr, wdata, wstrb,
        output rdata, err
    );

endinterface : slave_bus_if

// ==== soc_consts.svh ====
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// ====================
// Data path
// ====================

// Data and address width
`define SOC_DATA_W 32

// ====================
// Memory map
// ====================

// On-chip RAM
`define RAM_BASE 32'h0000_0000
`define RAM_WORDS 256

// Peripheral windows
`define TIMER_BASE 32'h1000_0000
`define GPIO_BASE 32'h1000_0100
`define SLAVE_WINDOW 32'h0000_0100

// Register counts per peripheral
`define TIMER_REGS 3
`define GPIO_REGS 3

// GPIO pins and interrupt sources
`define GPIO_W 8
`define IRQ_SOURCES 3

`endif

// ==== soc_pkg.sv ====
package soc_pkg;

    // Width of a master write
    typedef enum logic [1:0] {
        ACC_BYTE = 2'd0,
        ACC_HALF = 2'd1,
        ACC_WORD = 2'd2
    } access_width_e;

    // Slave picked by the address decoder
    typedef enum logic [1:0] {
        SEL_RAM   = 2'd0,
        SEL_TIMER = 2'd1,
        SEL_GPIO  = 2'd2,
        SEL_NONE  = 2'd3
    } slave_sel_e;

    // Timer register word offsets
    typedef enum logic [1:0] {
        TMR_COUNT   = 2'd0,
        TMR_COMPARE = 2'd1,
        TMR_CONTROL = 2'd2
    } timer_reg_e;

    // GPIO register word offsets
    typedef enum logic [1:0] {
        GPIO_OUT  = 2'd0,
        GPIO_IN   = 2'd1,
        GPIO_MASK = 2'd2
    } gpio_reg_e;

    // Interrupt source lines, lowest index wins
    typedef enum logic [1:0] {
        IRQ_TIMER   = 2'd0,
        IRQ_GPIO    = 2'd1,
        IRQ_BUS_ERR = 2'd2
    } irq_src_e;

endpackage : soc_pkg

// ==== soc_top.sv ====
`timescale 1ns/1ns

`include "soc_consts.svh"

module soc_top (
    input  logic sys_clk,
    input  logic rst_n_i,

    input  logic wr_req_i,
    input  logic [`SOC_DATA_W-1:0] wr_addr_i,
    input  logic [`SOC_DATA_W-1:0] wr_data_i,
    input  soc_pkg::access_width_e wr_width_i,
    output logic wr_done_o,

    input  logic rd_req_i,
    input  logic [`SOC_DATA_W-1:0] rd_addr_i,
    output logic [`SOC_DATA_W-1:0] rd_data_o,
    output logic rd_done_o,

    output logic bus_err_o,

    input  logic [`GPIO_W-1:0] gpio_in_i,
    output logic [`GPIO_W-1:0] gpio_out_o,

    output logic irq_o,
    output logic [$clog2(`IRQ_SOURCES)-1:0] irq_vector_o,
    input  logic irq_ack_i
);

    logic rst_meta_q;
    logic rst_n_sync;
    logic [`IRQ_SOURCES-1:0] irq_src;

    // Two-flop reset synchronizer
    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rst_meta_q <= 1'b0;
            rst_n_sync <= 1'b0;
        end else begin
            rst_meta_q <= 1'b1;
            rst_n_sync <= rst_meta_q;
        end
    end

// ====================
// Interconnect
// ====================

    slave_bus_if ram_bus ();
    slave_bus_if tmr_bus ();
    slave_bus_if gpio_bus ();

    bus_decoder u_bus_decoder (
        .sys_clk    ( sys_clk    ),
        .rst_n_i    ( rst_n_sync ),
        .wr_req_i   ( wr_req_i   ),
        .wr_addr_i  ( wr_addr_i  ),
        .wr_data_i  ( wr_data_i  ),
        .wr_width_i ( wr_width_i ),
        .rd_req_i   ( rd_req_i   ),
        .rd_addr_i  ( rd_addr_i  ),
        .wr_done_o  ( wr_done_o  ),
        .rd_done_o  ( rd_done_o  ),
        .rd_data_o  ( rd_data_o  ),
        .bus_err_o  ( bus_err_o  ),
        .ram_bus    ( ram_bus    ),
        .tmr_bus    ( tmr_bus    ),
        .gpio_bus   ( gpio_bus   )
    );

// ====================
// Slaves
// ====================

    data_ram u_data_ram (
        .sys_clk ( sys_clk    ),
        .rst_n_i ( rst_n_sync ),
        .bus     ( ram_bus    )
    );

    system_timer u_system_timer (
        .sys_clk ( sys_clk                      ),
        .rst_n_i ( rst_n_sync                   ),
        .bus     ( tmr_bus                      ),
        .irq_o   ( irq_src[soc_pkg::IRQ_TIMER]  )
    );

    gpio_port u_gpio_port (
        .sys_clk    ( sys_clk                    ),
        .rst_n_i    ( rst_n_sync                 ),
        .bus        ( gpio_bus                   ),
        .gpio_in_i  ( gpio_in_i                  ),
        .gpio_out_o ( gpio_out_o                 ),
        .irq_o      ( irq_src[soc_pkg::IRQ_GPIO] )
    );

    // Bus errors raise their own interrupt
    assign irq_src[soc_pkg::IRQ_BUS_ERR] = bus_err_o;

    interrupt_controller u_interrupt_controller (
        .sys_clk      ( sys_clk      ),
        .rst_n_i      ( rst_n_sync   ),
        .irq_src_i    ( irq_src      ),
        .irq_ack_i    ( irq_ack_i    ),
        .irq_o        ( irq_o        ),
        .irq_vector_o ( irq_vector_o )
    );

endmodule : soc_top

// ==== system_timer.sv ====
`timescale 1ns/1ns

`include "soc_consts.svh"

module system_timer (
    input  logic sys_clk,
    input  logic rst_n_i,

    slave_bus_if.slave bus,

    output logic irq_o
);

    soc_pkg::timer_reg_e reg_idx;
    logic idx_ok;
    logic match;
    logic en_q;
    logic [`SOC_DATA_W-1:0] count_q;
    logic [`SOC_DATA_W-1:0] compare_q;

    // Merge the enabled byte lanes into a register
    function automatic logic [`SOC_DATA_W-1:0] merge_lanes(
        input logic [`SOC_DATA_W-1:0] old_val,
        input logic [`SOC_DATA_W-1:0] new_val,
        input logic [3:0] strb
    );
        logic [`SOC_DATA_W-1:0] res;
        res = old_val;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign idx_ok = bus.word_addr < `TIMER_REGS;
    assign reg_idx = soc_pkg::timer_reg_e'(bus.word_addr[1:0]);
    assign match = en_q && (count_q == compare_q);

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
            compare_q <= '0;
            en_q <= 1'b0;
            irq_o <= 1'b0;
            bus.err <= 1'b0;
        end else begin
            irq_o <= match;
            bus.err <= (bus.wr_req | bus.rd_req) & ~idx_ok;
            // Wrap on match, otherwise count while enabled
            if (match) begin
                count_q <= '0;
            end else if (en_q) begin
                count_q <= count_q + 1'b1;
            end
            // A bus write overrides the count update
            if (bus.wr_req && idx_ok) begin
                case (reg_idx)
                    soc_pkg::TMR_COUNT:   count_q <= merge_lanes(count_q, bus.wdata, bus.wstrb);
                    soc_pkg::TMR_COMPARE: compare_q <= merge_lanes(compare_q, bus.wdata, bus.wstrb);
                    soc_pkg::TMR_CONTROL: begin
                        if (bus.wstrb[0]) begin
                            en_q <= bus.wdata[0];
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (bus.rd_req) begin
            case (reg_idx)
                soc_pkg::TMR_COUNT:   bus.rdata <= count_q;
                soc_pkg::TMR_COMPARE: bus.rdata <= compare_q;
                soc_pkg::TMR_CONTROL: bus.rdata <= {{(`SOC_DATA_W-1){1'b0}}, en_q};
                default:              bus.rdata <= '0;
            endcase
        end
    end

endmodule : system_timer

// ==== tb_soc_tasks.svh ====
`ifndef TB_SOC_TASKS_SVH
`define TB_SOC_TASKS_SVH

// ====================
// Checks and bus access
// ====================

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        $display("sim failed");
        $fatal(1);
    end
endtask

task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("sim failed");
    $fatal(1);
endtask

// Called one drive delay after a rising edge, returns the same way
task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                         input soc_pkg::access_width_e width, output logic err);
    wr_req   = 1'b1;
    wr_addr  = addr;
    wr_data  = data;
    wr_width = width;
    @(posedge sys_clk);
    #DRIVE_DELAY;
    wr_req = 1'b0;
    if (wr_done !== 1'b1) begin
        stop_with_error($sformatf("Write to 0x%h got no done pulse one cycle later", addr));
    end
    err = bus_err;
endtask

task automatic bus_read(input logic [31:0] addr, output logic [31:0] data, output logic err);
    rd_req  = 1'b1;
    rd_addr = addr;
    @(posedge sys_clk);
    #DRIVE_DELAY;
    rd_req = 1'b0;
    if (rd_done !== 1'b1) begin
        stop_with_error($sformatf("Read from 0x%h got no done pulse one cycle later", addr));
    end
    data = rd_data;
    err  = bus_err;
endtask

task automatic write_ok(input logic [31:0] addr, input logic [31:0] data,
                        input soc_pkg::access_width_e width);
    logic err;
    bus_write(addr, data, width, err);
    check_val("bus_err_o", err, 1'b0);
endtask

task automatic read_ok(input logic [31:0] addr, output logic [31:0] data);
    logic err;
    bus_read(addr, data, err);
    check_val("bus_err_o", err, 1'b0);
endtask

// Bytes touched by an access of this width at this address
function automatic logic [31:0] lane_mask(input soc_pkg::access_width_e width,
                                          input logic [31:0] addr);
    case (width)
        soc_pkg::ACC_HALF: return addr[1] ? 32'hFFFF_0000 : 32'h0000_FFFF;
        soc_pkg::ACC_BYTE: return 32'h0000_00FF << (8 * addr[1:0]);
        default:           return 32'hFFFF_FFFF;
    endcase
endfunction

// ====================
// Interrupt helpers
// ====================

task automatic ack_irq();
    irq_ack = 1'b1;
    @(posedge sys_clk);
    #DRIVE_DELAY;
    irq_ack = 1'b0;
endtask

// Clears whatever earlier tests left pending
task automatic drain_irqs();
    int n;
    n = 0;
    while (irq && n <= `IRQ_SOURCES) begin
        ack_irq();
        n++;
    end
    if (irq) begin
        stop_with_error("irq_o stays high after acknowledging every source");
    end
endtask

task automatic wait_for_irq(input int max_cycles);
    int n;
    n = 0;
    while (!irq && n < max_cycles) begin
        @(posedge sys_clk);
        #DRIVE_DELAY;
        n++;
    end
    if (!irq) begin
        stop_with_error($sformatf("irq_o did not rise within %0d cycles", max_cycles));
    end
endtask

// ====================
// Directed tests
// ====================

task automatic test_ram_lanes();
    logic [31:0] model [8];
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] mask;
    for (int i = 0; i < 8; i++) begin
        data = $urandom();
        write_ok(`RAM_BASE + 32'(4 * i), data, soc_pkg::ACC_WORD);
        model[i] = data;
    end
    for (int i = 0; i < 8; i++) begin
        addr = `RAM_BASE + 32'(4 * i + 2 * (i % 2));
        data = $urandom();
        write_ok(addr, data, soc_pkg::ACC_HALF);
        mask = lane_mask(soc_pkg::ACC_HALF, addr);
        model[i] = (model[i] & ~mask) | (data & mask);
    end
    for (int i = 0; i < 8; i++) begin
        addr = `RAM_BASE + 32'(4 * i + (i % 4));
        data = $urandom();
        write_ok(addr, data, soc_pkg::ACC_BYTE);
        mask = lane_mask(soc_pkg::ACC_BYTE, addr);
        model[i] = (model[i] & ~mask) | (data & mask);
    end
    for (int i = 0; i < 8; i++) begin
        read_ok(`RAM_BASE + 32'(4 * i), data);
        check_val($sformatf("rd_data_o ram[%0d]", i), data, model[i]);
    end
endtask

task automatic test_bus_errors();
    logic [31:0] data;
    logic err;
    bus_write(32'h2000_0000, $urandom(), soc_pkg::ACC_WORD, err);
    check_val("bus_err_o unmapped write", err, 1'b1);
    bus_read(32'h1000_0200, data, err);
    check_val("bus_err_o unmapped read", err, 1'b1);
    check_val("rd_data_o unmapped read", data, 32'h0);
    bus_write(`TIMER_BASE + 4 * `TIMER_REGS, $urandom(), soc_pkg::ACC_WORD, err);
    check_val("bus_err_o timer index", err, 1'b1);
    bus_write(`GPIO_BASE + 4 * soc_pkg::GPIO_IN, $urandom(), soc_pkg::ACC_WORD, err);
    check_val("bus_err_o gpio in write", err, 1'b1);
endtask

task automatic test_gpio_io();
    logic [31:0] data;
    logic [`GPIO_W-1:0] pins;
    pins = `GPIO_W'($urandom());
    write_ok(`GPIO_BASE + 4 * soc_pkg::GPIO_OUT, 32'(pins), soc_pkg::ACC_WORD);
    check_val("gpio_out_o", gpio_out, pins);
    pins = `GPIO_W'($urandom());
    gpio_in = pins;
    repeat (3) @(posedge sys_clk);
    #DRIVE_DELAY;
    read_ok(`GPIO_BASE + 4 * soc_pkg::GPIO_IN, data);
    check_val("rd_data_o gpio in", data, 32'(pins));
endtask

task automatic test_timer_match();
    logic [31:0] count;
    drain_irqs();
    write_ok(`TIMER_BASE + 4 * soc_pkg::TMR_COMPARE, 32'd20, soc_pkg::ACC_WORD);
    write_ok(`TIMER_BASE + 4 * soc_pkg::TMR_CONTROL, 32'd1, soc_pkg::ACC_WORD);
    wait_for_irq(30);
    check_val("irq_vector_o", irq_vector, soc_pkg::IRQ_TIMER);
    read_ok(`TIMER_BASE + 4 * soc_pkg::TMR_COUNT, count);
    check_val("timer count below compare", count < 32'd20, 1'b1);
    // Stop the timer so it raises no more matches
    write_ok(`TIMER_BASE + 4 * soc_pkg::TMR_CONTROL, 32'd0, soc_pkg::ACC_WORD);
    drain_irqs();
endtask

task automatic test_irq_priority();
    logic [31:0] data;
    logic err;
    drain_irqs();
    write_ok(`GPIO_BASE + 4 * soc_pkg::GPIO_MASK, 32'hFF, soc_pkg::ACC_WORD);
    gpio_in = gpio_in ^ `GPIO_W'(1);
    wait_for_irq(8);
    check_val("irq_vector_o gpio", irq_vector, soc_pkg::IRQ_GPIO);
    bus_read(32'h3000_0000, data, err);
    check_val("bus_err_o", err, 1'b1);
    @(posedge sys_clk);
    #DRIVE_DELAY;
    check_val("irq_vector_o both pending", irq_vector, soc_pkg::IRQ_GPIO);
    ack_irq();
    check_val("irq_o after first ack", irq, 1'b1);
    check_val("irq_vector_o after first ack", irq_vector, soc_pkg::IRQ_BUS_ERR);
    ack_irq();
    check_val("irq_o after second ack", irq, 1'b0);
endtask

`endif

// ==== tb_soc.sv ====
`timescale 1ns/1ns

`include "soc_consts.svh"

module tb_soc;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 3;
    localparam int DRIVE_DELAY  = 2;

    // Cycle budget of each phase, sets the watchdog limit
    localparam int SETUP_BUDGET = 20;
    localparam int RAM_BUDGET   = 100;
    localparam int ERR_BUDGET   = 30;
    localparam int GPIO_BUDGET  = 30;
    localparam int TIMER_BUDGET = 60;
    localparam int IRQ_BUDGET   = 50;
    localparam int TOTAL_CYCLES = SETUP_BUDGET + RAM_BUDGET + ERR_BUDGET
                                + GPIO_BUDGET + TIMER_BUDGET + IRQ_BUDGET;

    logic sys_clk;
    logic rst_n_i;

    logic wr_req;
    logic [`SOC_DATA_W-1:0] wr_addr;
    logic [`SOC_DATA_W-1:0] wr_data;
    soc_pkg::access_width_e wr_width;
    logic wr_done;

    logic rd_req;
    logic [`SOC_DATA_W-1:0] rd_addr;
    logic [`SOC_DATA_W-1:0] rd_data;
    logic rd_done;

    logic bus_err;
    logic [`GPIO_W-1:0] gpio_in;
    logic [`GPIO_W-1:0] gpio_out;
    logic irq;
    logic [$clog2(`IRQ_SOURCES)-1:0] irq_vector;
    logic irq_ack;

    soc_top u_soc_top (
        .sys_clk      ( sys_clk    ),
        .rst_n_i      ( rst_n_i    ),
        .wr_req_i     ( wr_req     ),
        .wr_addr_i    ( wr_addr    ),
        .wr_data_i    ( wr_data    ),
        .wr_width_i   ( wr_width   ),
        .wr_done_o    ( wr_done    ),
        .rd_req_i     ( rd_req     ),
        .rd_addr_i    ( rd_addr    ),
        .rd_data_o    ( rd_data    ),
        .rd_done_o    ( rd_done    ),
        .bus_err_o    ( bus_err    ),
        .gpio_in_i    ( gpio_in    ),
        .gpio_out_o   ( gpio_out   ),
        .irq_o        ( irq        ),
        .irq_vector_o ( irq_vector ),
        .irq_ack_i    ( irq_ack    )
    );

    `include "tb_soc_tasks.svh"

    always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

// ====================
// Watchdog
// ====================

    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles, the tests did not finish", TOTAL_CYCLES);
        $display("sim failed");
        $fatal(1);
    end

// ====================
// Test sequence
// ====================

    initial begin
        sys_clk  = 1'b0;
        rst_n_i  = 1'b0;
        wr_req   = 1'b0;
        wr_addr  = '0;
        wr_data  = '0;
        wr_width = soc_pkg::ACC_WORD;
        rd_req   = 1'b0;
        rd_addr  = '0;
        gpio_in  = '0;
        irq_ack  = 1'b0;
        void'($urandom(32'h2023));

        repeat (RESET_CYCLES) @(posedge sys_clk);
        #DRIVE_DELAY;
        rst_n_i = 1'b1;
        // Internal reset leaves the synchronizer two edges later
        repeat (2) @(posedge sys_clk);
        #DRIVE_DELAY;

        check_val("wr_done_o", wr_done, 1'b0);
        check_val("rd_done_o", rd_done, 1'b0);
        check_val("bus_err_o", bus_err, 1'b0);
        check_val("irq_o", irq, 1'b0);
        check_val("gpio_out_o", gpio_out, '0);

        test_ram_lanes();
        test_bus_errors();
        test_gpio_io();
        test_timer_match();
        test_irq_priority();

        $display("sim passed");
        $finish;
    end

endmodule : tb_soc
